// ==== project.f ====
+incdir+hw
hw/upsize_pkg.sv
hw/aw_burst_planner.sv
hw/w_lane_packer.sv
hw/w_beat_stage.sv
hw/axi_write_upsizer.sv
verification/tb_axi_write_upsizer.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0 -Wno-fatal
TOP       := tb_axi_write_upsizer
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST)) hw/upsize_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_axi_write_upsizer.sv ====
`timescale 1ns/10ps

module tb_axi_write_upsizer;

  typedef struct packed {
    upsize_pkg::addr_t  addr;
    upsize_pkg::len_t   len;
    upsize_pkg::size_t  size;
    upsize_pkg::burst_t burst;
    upsize_pkg::cache_t cache;
    logic [31:0]        seed;
  } test_row_t;

  localparam int NumRows  = 9;
  localparam int MaxBeats = 16;

  logic                  clk_i;
  logic                  rst_ni;
  upsize_pkg::aw_chan_t  slv_aw_i;
  logic                  slv_aw_valid_i;
  logic                  slv_aw_ready_o;
  upsize_pkg::narrow_w_t slv_w_i;
  logic                  slv_w_valid_i;
  logic                  slv_w_ready_o;
  upsize_pkg::b_chan_t   slv_b_o;
  logic                  slv_b_valid_o;
  logic                  slv_b_ready_i;
  upsize_pkg::aw_chan_t  mst_aw_o;
  logic                  mst_aw_valid_o;
  logic                  mst_aw_ready_i;
  upsize_pkg::wide_w_t   mst_w_o;
  logic                  mst_w_valid_o;
  logic                  mst_w_ready_i;
  upsize_pkg::b_chan_t   mst_b_i;
  logic                  mst_b_valid_i;
  logic                  mst_b_ready_o;

  test_row_t                rows [NumRows];
  upsize_pkg::narrow_data_t ndata [MaxBeats];
  upsize_pkg::wide_data_t   exp_data [MaxBeats];
  upsize_pkg::wide_strb_t   exp_strb [MaxBeats];
  logic                     exp_last [MaxBeats];
  int                       exp_count;
  upsize_pkg::aw_chan_t     exp_aw;
  logic [31:0]              rng;
  int                       errors;
  int                       tests_passed;
  int                       tests_failed;
  int                       cycle_count = 0;
  int                       cycle_limit = 100;

  axi_write_upsizer u_axi_write_upsizer (.*);

  always #10 clk_i = ~clk_i;

  // Run limit from the table length
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Run timed out after %0d cycles before all tests finished", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("FAIL %s expected 0x%h got 0x%h", sig, exp_v, act_v);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  task automatic record_result(input string name, input int err_start);
    if (errors == err_start) begin
      tests_passed++;
      $display("Test %s ok", name);
    end else begin
      tests_failed++;
      $display("Test %s had %0d errors", name, errors - err_start);
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Expected wide AW and wide beats of one row
  function automatic void predict_burst(input int idx, input test_row_t r);
    upsize_pkg::addr_t      a;
    upsize_pkg::addr_t      mask;
    upsize_pkg::addr_t      nxt;
    upsize_pkg::addr_t      final_a;
    upsize_pkg::wide_data_t d;
    upsize_pkg::wide_strb_t s;
    logic                   up;
    int                     mi;
    int                     si;
    int                     src;
    up      = (r.burst == upsize_pkg::BURST_INCR) && ((r.cache & 4'b0010) != 4'b0000);
    mask    = (32'd1 << r.size) - 32'd1;
    final_a = (r.addr & ~mask) + (32'(r.len) << r.size);
    exp_aw  = '{id: 4'(idx), addr: r.addr, len: r.len, size: r.size,
                burst: r.burst, cache: r.cache};
    if (up) begin
      exp_aw.len  = 8'(((final_a & ~32'd7) - (r.addr & ~32'd7)) >> 3);
      exp_aw.size = 3'd3;
    end
    exp_count = 0;
    d = '0;
    s = '0;
    a = r.addr;
    for (int k = 0; k <= int'(r.len); k++) begin
      mi = int'(a[2:0]);
      si = int'(a[1:0]);
      for (int b = 0; b < 8; b++) begin
        src = b - mi + si;
        if ((b >= mi) && ((b - mi) < (1 << r.size)) && (src < 4)) begin
          d[8*b +: 8] = ndata[k][8*src +: 8];
          s[b]        = 1'b1;
        end
      end
      nxt = (a & ~mask) + (32'd1 << r.size);
      if (!up || (k == int'(r.len)) || (nxt[31:3] != a[31:3])) begin
        exp_data[exp_count] = d;
        exp_strb[exp_count] = s;
        exp_last[exp_count] = (k == int'(r.len));
        exp_count++;
        d = '0;
        s = '0;
      end
      a = nxt;
    end
  endfunction

  // --------------------
  // Per-row traffic
  // --------------------

  task automatic run_row(input int idx);
    test_row_t           r;
    upsize_pkg::b_chan_t exp_b;
    int                  err_start;
    int                  nb;
    int                  wb;
    logic                aw_fire;
    logic                w_fire;
    logic                last_fire;
    logic                maw_done;
    logic                b_done;
    r         = rows[idx];
    err_start = errors;
    for (int k = 0; k < MaxBeats; k++) begin
      rng      = lcg_next(rng);
      ndata[k] = rng ^ r.seed;
    end
    predict_burst(idx, r);
    exp_b     = '{id: 4'(idx), resp: r.seed[1:0]};
    nb        = 0;
    wb        = 0;
    aw_fire   = 1'b0;
    w_fire    = 1'b0;
    last_fire = 1'b0;
    maw_done  = 1'b0;
    b_done    = 1'b0;
    @(negedge clk_i);
    slv_aw_i       = exp_aw;
    slv_aw_i.len   = r.len;
    slv_aw_i.size  = r.size;
    slv_aw_valid_i = 1'b1;
    while (!b_done) begin
      if (aw_fire) slv_aw_valid_i = 1'b0;
      if (w_fire) nb++;
      if (last_fire && (slv_aw_ready_o !== 1'b1)) begin
        report_mismatch("slv_aw_ready_o", 64'h1, 64'(slv_aw_ready_o));
      end
      // Slave ready about three cycles in four
      rng            = lcg_next(rng);
      mst_aw_ready_i = rng[16] | rng[17];
      mst_w_ready_i  = rng[18] | rng[19];
      slv_b_ready_i  = rng[20] | rng[21];
      slv_w_valid_i  = (nb <= int'(r.len));
      slv_w_i        = '{data: ndata[nb], strb: 4'hF, last: (nb == int'(r.len))};
      mst_b_valid_i  = maw_done && (wb == exp_count);
      mst_b_i        = exp_b;
      #1;
      aw_fire   = slv_aw_valid_i && slv_aw_ready_o;
      w_fire    = slv_w_valid_i && slv_w_ready_o;
      last_fire = 1'b0;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        if (maw_done) report_problem($sformatf("test %0d sent a second wide AW", idx));
        if (mst_aw_o.len !== exp_aw.len)
          report_mismatch("mst_aw_o.len", 64'(exp_aw.len), 64'(mst_aw_o.len));
        if (mst_aw_o.size !== exp_aw.size)
          report_mismatch("mst_aw_o.size", 64'(exp_aw.size), 64'(mst_aw_o.size));
        if (mst_aw_o !== exp_aw)
          report_mismatch("mst_aw_o", 64'(exp_aw), 64'(mst_aw_o));
        maw_done = 1'b1;
      end
      if (mst_w_valid_o && mst_w_ready_i) begin
        if (wb >= exp_count) begin
          report_problem($sformatf("test %0d produced more wide beats than expected", idx));
        end else begin
          if (mst_w_o.data !== exp_data[wb])
            report_mismatch($sformatf("mst_w_o.data[%0d]", wb), exp_data[wb], mst_w_o.data);
          if (mst_w_o.strb !== exp_strb[wb])
            report_mismatch($sformatf("mst_w_o.strb[%0d]", wb), 64'(exp_strb[wb]),
                            64'(mst_w_o.strb));
          if (mst_w_o.last !== exp_last[wb])
            report_mismatch($sformatf("mst_w_o.last[%0d]", wb), 64'(exp_last[wb]),
                            64'(mst_w_o.last));
          last_fire = mst_w_o.last;
        end
        wb++;
      end
      if (mst_b_valid_i && slv_b_ready_i) begin
        if (mst_b_ready_o !== 1'b1) report_mismatch("mst_b_ready_o", 64'h1, 64'(mst_b_ready_o));
        if (slv_b_valid_o !== 1'b1) report_mismatch("slv_b_valid_o", 64'h1, 64'(slv_b_valid_o));
        if (slv_b_o !== exp_b) report_mismatch("slv_b_o", 64'(exp_b), 64'(slv_b_o));
        b_done = 1'b1;
      end
      @(negedge clk_i);
    end
    mst_b_valid_i = 1'b0;
    slv_w_valid_i = 1'b0;
    record_result($sformatf("%0d addr 0x%h len %0d size %0d", idx, r.addr, r.len, r.size),
                  err_start);
  endtask

  initial begin
    int err_start;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    slv_aw_i       = '0;
    slv_aw_valid_i = 1'b0;
    slv_w_i        = '0;
    slv_w_valid_i  = 1'b0;
    slv_b_ready_i  = 1'b0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_i        = '0;
    mst_b_valid_i  = 1'b0;
    rng            = 32'h5c979167;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;

    // addr, len, size, burst, cache, data seed
    rows[0] = '{32'h0000_1000, 8'd3, 3'd2, upsize_pkg::BURST_FIXED, 4'h2, 32'h0000_0011};
    rows[1] = '{32'h0000_2004, 8'd4, 3'd2, upsize_pkg::BURST_INCR,  4'h0, 32'h0000_0022};
    rows[2] = '{32'h0000_3000, 8'd7, 3'd2, upsize_pkg::BURST_INCR,  4'h2, 32'h0000_0033};
    rows[3] = '{32'h0000_4000, 8'd4, 3'd2, upsize_pkg::BURST_INCR,  4'hF, 32'h0000_0040};
    rows[4] = '{32'h0000_5006, 8'd5, 3'd1, upsize_pkg::BURST_INCR,  4'h2, 32'h0000_0051};
    rows[5] = '{32'h0000_6003, 8'd9, 3'd0, upsize_pkg::BURST_INCR,  4'h3, 32'h0000_0062};
    rows[6] = '{32'h0000_7006, 8'd3, 3'd2, upsize_pkg::BURST_INCR,  4'h2, 32'h0000_0073};
    rows[7] = '{32'h0000_8008, 8'd1, 3'd2, upsize_pkg::BURST_WRAP,  4'h2, 32'h0000_0080};
    rows[8] = '{32'h0000_9000, 8'd0, 3'd2, upsize_pkg::BURST_INCR,  4'h2, 32'h0000_0091};

    for (int i = 0; i < NumRows; i++) begin
      cycle_limit = cycle_limit + 40 * (int'(rows[i].len) + 1);
    end

    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    err_start = errors;
    if (mst_aw_valid_o !== 1'b0) report_mismatch("mst_aw_valid_o", 64'h0, 64'(mst_aw_valid_o));
    if (mst_w_valid_o !== 1'b0) report_mismatch("mst_w_valid_o", 64'h0, 64'(mst_w_valid_o));
    if (slv_w_ready_o !== 1'b0) report_mismatch("slv_w_ready_o", 64'h0, 64'(slv_w_ready_o));
    if (slv_aw_ready_o !== 1'b1) report_mismatch("slv_aw_ready_o", 64'h1, 64'(slv_aw_ready_o));
    record_result("reset state", err_start);

    for (int i = 0; i < NumRows; i++) begin
      run_row(i);
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_passed + tests_failed, tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/axi_write_upsizer.sv ====
`timescale 1ns/10ps

module axi_write_upsizer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Narrow side toward the 32-bit master
  input  upsize_pkg::aw_chan_t  slv_aw_i,
  input  logic                  slv_aw_valid_i,
  output logic                  slv_aw_ready_o,
  input  upsize_pkg::narrow_w_t slv_w_i,
  input  logic                  slv_w_valid_i,
  output logic                  slv_w_ready_o,
  output upsize_pkg::b_chan_t   slv_b_o,
  output logic                  slv_b_valid_o,
  input  logic                  slv_b_ready_i,
  // Wide side toward the 64-bit slave
  output upsize_pkg::aw_chan_t  mst_aw_o,
  output logic                  mst_aw_valid_o,
  input  logic                  mst_aw_ready_i,
  output upsize_pkg::wide_w_t   mst_w_o,
  output logic                  mst_w_valid_o,
  input  logic                  mst_w_ready_i,
  input  upsize_pkg::b_chan_t   mst_b_i,
  input  logic                  mst_b_valid_i,
  output logic                  mst_b_ready_o
);

  upsize_pkg::burst_ctx_t burst_ctx;
  logic                   burst_start;
  logic                   burst_done;
  logic                   w_open;
  upsize_pkg::wide_w_t    pack_w;
  logic                   pack_valid;
  logic                   take_ready;
  logic                   beat_taken;

  // --------------------
  // Input side
  // --------------------

  aw_burst_planner u_aw_burst_planner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_aw_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_o       (mst_aw_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .burst_ctx_o    (burst_ctx),
    .burst_start_o  (burst_start),
    .w_open_o       (w_open),
    .burst_done_i   (burst_done)
  );

  // Lane packing
  w_lane_packer u_w_lane_packer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .burst_ctx_i    (burst_ctx),
    .burst_start_i  (burst_start),
    .w_open_i       (w_open),
    .burst_done_o   (burst_done),
    .slv_w_i        (slv_w_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .pack_w_o       (pack_w),
    .pack_valid_o   (pack_valid),
    .take_ready_i   (take_ready),
    .beat_taken_i   (beat_taken)
  );

  // --------------------
  // Output side
  // --------------------

  w_beat_stage u_w_beat_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pack_w_i       (pack_w),
    .pack_valid_i   (pack_valid),
    .take_ready_o   (take_ready),
    .beat_taken_o   (beat_taken),
    .mst_w_o        (mst_w_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_ready_i  (mst_w_ready_i),
    .mst_b_i        (mst_b_i),
    .mst_b_valid_i  (mst_b_valid_i),
    .mst_b_ready_o  (mst_b_ready_o),
    .slv_b_o        (slv_b_o),
    .slv_b_valid_o  (slv_b_valid_o),
    .slv_b_ready_i  (slv_b_ready_i)
  );

endmodule

// ==== hw/w_beat_stage.sv ====
`timescale 1ns/10ps

module w_beat_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Packed beat from the packer
  input  upsize_pkg::wide_w_t pack_w_i,
  input  logic                pack_valid_i,
  output logic                take_ready_o,
  output logic                beat_taken_o,
  // Wide W toward the slave
  output upsize_pkg::wide_w_t mst_w_o,
  output logic                mst_w_valid_o,
  input  logic                mst_w_ready_i,
  // B response path
  input  upsize_pkg::b_chan_t mst_b_i,
  input  logic                mst_b_valid_i,
  output logic                mst_b_ready_o,
  output upsize_pkg::b_chan_t slv_b_o,
  output logic                slv_b_valid_o,
  input  logic                slv_b_ready_i
);

  upsize_pkg::wide_w_t w_q;
  logic                w_valid_q;

  // --------------------
  // W register
  // --------------------

  // Free now, or freed by the slave this cycle
  assign take_ready_o  = !w_valid_q || mst_w_ready_i;
  assign beat_taken_o  = w_valid_q && mst_w_ready_i;

  assign mst_w_o       = w_q;
  assign mst_w_valid_o = w_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_valid_q <= 1'b0;
    end else if (take_ready_o) begin
      w_valid_q <= pack_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_ready_o && pack_valid_i) begin
      w_q <= pack_w_i;
    end
  end

  // --------------------
  // B forwarding
  // --------------------

  // Wide and narrow B are the same channel
  assign slv_b_o       = mst_b_i;
  assign slv_b_valid_o = mst_b_valid_i;
  assign mst_b_ready_o = slv_b_ready_i;

  // A stalled wide beat is neither dropped nor changed
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_w_valid_o && !mst_w_ready_i |=> mst_w_valid_o && $stable(mst_w_o));

endmodule

// ==== hw/w_lane_packer.sv ====
`timescale 1ns/10ps

`include "upsize_config.svh"

module w_lane_packer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Burst control from the planner
  input  upsize_pkg::burst_ctx_t burst_ctx_i,
  input  logic                   burst_start_i,
  input  logic                   w_open_i,
  output logic                   burst_done_o,
  // Narrow W from the master
  input  upsize_pkg::narrow_w_t  slv_w_i,
  input  logic                   slv_w_valid_i,
  output logic                   slv_w_ready_o,
  // Packed beat toward the output stage
  output upsize_pkg::wide_w_t    pack_w_o,
  output logic                   pack_valid_o,
  input  logic                   take_ready_i,
  input  logic                   beat_taken_i
);

  localparam int NarrowBytes = `UPS_NARROW_WIDTH / 8;
  localparam int WideBytes   = `UPS_WIDE_WIDTH / 8;
  localparam int NarrowOffs  = $clog2(NarrowBytes);

  logic                     active_q;
  upsize_pkg::len_t         len_q;
  logic                     last_handed_q;
  upsize_pkg::addr_t        addr_q;
  upsize_pkg::wide_data_t   word_data_q;
  upsize_pkg::wide_strb_t   word_strb_q;

  logic                     w_acc;
  logic                     emit;
  upsize_pkg::addr_t        size_mask;
  upsize_pkg::addr_t        next_addr;
  upsize_pkg::wide_data_t   steer_data;
  upsize_pkg::wide_strb_t   steer_strb;

  // --------------------
  // Lane steering
  // --------------------

  always_comb begin
    int mi;
    int si;
    int src;
    mi         = int'(addr_q[upsize_pkg::WIDE_SIZE-1:0]);
    si         = int'(addr_q[NarrowOffs-1:0]);
    steer_data = '0;
    steer_strb = '0;
    for (int b = 0; b < WideBytes; b++) begin
      src = b - mi + si;
      if ((b >= mi) && ((b - mi) < (1 << burst_ctx_i.size)) && (src < NarrowBytes)) begin
        steer_data[8*b +: 8] = slv_w_i.data[8*src +: 8];
        steer_strb[b]        = slv_w_i.strb[src];
      end
    end
  end

  // Address of the following narrow beat
  assign size_mask = (upsize_pkg::addr_t'(1) << burst_ctx_i.size) - upsize_pkg::addr_t'(1);
  assign next_addr = (addr_q & ~size_mask) + (upsize_pkg::addr_t'(1) << burst_ctx_i.size);

  // --------------------
  // Emission
  // --------------------

  assign slv_w_ready_o = w_open_i && active_q && take_ready_i;
  assign w_acc         = slv_w_valid_i && slv_w_ready_o;

  // Send when the word is full, the burst ends or beats are not merged
  assign emit = !burst_ctx_i.upsize || (len_q == '0) ||
                ((next_addr >> upsize_pkg::WIDE_SIZE) != (addr_q >> upsize_pkg::WIDE_SIZE));

  assign pack_w_o.data = word_data_q | steer_data;
  assign pack_w_o.strb = word_strb_q | steer_strb;
  assign pack_w_o.last = (len_q == '0);
  assign pack_valid_o  = w_acc && emit;

  // Last wide beat leaves the stage
  assign burst_done_o  = beat_taken_i && last_handed_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q      <= 1'b0;
      len_q         <= '0;
      last_handed_q <= 1'b0;
    end else begin
      if (burst_start_i) begin
        active_q <= 1'b1;
        len_q    <= burst_ctx_i.len;
      end else if (w_acc) begin
        active_q <= (len_q != '0);
        len_q    <= len_q - 1'b1;
      end

      if (pack_valid_o && pack_w_o.last) begin
        last_handed_q <= 1'b1;
      end else if (burst_done_o) begin
        last_handed_q <= 1'b0;
      end
    end
  end

  // Address walk and the word under construction
  always_ff @(posedge clk_i) begin
    if (burst_start_i) begin
      addr_q      <= burst_ctx_i.start_addr;
      word_data_q <= '0;
      word_strb_q <= '0;
    end else if (w_acc) begin
      addr_q      <= next_addr;
      word_data_q <= emit ? '0 : pack_w_o.data;
      word_strb_q <= emit ? '0 : pack_w_o.strb;
    end
  end

  // The master's last beat is the final one the burst has room for
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_acc |-> (slv_w_i.last == (len_q == '0)));

endmodule

// ==== hw/aw_burst_planner.sv ====
`timescale 1ns/10ps

module aw_burst_planner (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Narrow AW from the master
  input  upsize_pkg::aw_chan_t   slv_aw_i,
  input  logic                   slv_aw_valid_i,
  output logic                   slv_aw_ready_o,
  // Wide AW toward the slave
  output upsize_pkg::aw_chan_t   mst_aw_o,
  output logic                   mst_aw_valid_o,
  input  logic                   mst_aw_ready_i,
  // Burst control toward the packer
  output upsize_pkg::burst_ctx_t burst_ctx_o,
  output logic                   burst_start_o,
  output logic                   w_open_o,
  input  logic                   burst_done_i
);

  localparam upsize_pkg::addr_t WideMask =
    (upsize_pkg::addr_t'(1) << upsize_pkg::WIDE_SIZE) - upsize_pkg::addr_t'(1);

  upsize_pkg::w_state_t   state_q;
  upsize_pkg::aw_chan_t   aw_q;
  logic                   aw_valid_q;
  upsize_pkg::burst_ctx_t ctx_q;

  logic                   aw_hs;
  logic                   upsize;
  upsize_pkg::addr_t      size_mask;
  upsize_pkg::addr_t      first_addr;
  upsize_pkg::addr_t      final_addr;
  upsize_pkg::len_t       wide_len;

  // --------------------
  // Burst planning
  // --------------------

  // Only modifiable INCR bursts may be merged into wide beats
  always_comb begin
    case (slv_aw_i.burst)
      upsize_pkg::BURST_INCR:
        upsize = |(slv_aw_i.cache & upsize_pkg::CACHE_MODIFIABLE);
      upsize_pkg::BURST_FIXED,
      upsize_pkg::BURST_WRAP:
        upsize = 1'b0;
      default:
        upsize = 1'b0;
    endcase
  end

  // Wide length from the first and final wide words the burst touches
  assign size_mask  = (upsize_pkg::addr_t'(1) << slv_aw_i.size) - upsize_pkg::addr_t'(1);
  assign first_addr = slv_aw_i.addr & ~size_mask;
  assign final_addr = first_addr + (upsize_pkg::addr_t'(slv_aw_i.len) << slv_aw_i.size);
  assign wide_len   = upsize_pkg::len_t'(((final_addr & ~WideMask) -
                                          (slv_aw_i.addr & ~WideMask)) >>
                                         upsize_pkg::WIDE_SIZE);

  // --------------------
  // Handshakes
  // --------------------

  // A new burst may enter in the cycle the previous one drains
  assign slv_aw_ready_o = (state_q == upsize_pkg::W_IDLE) || burst_done_i;
  assign aw_hs          = slv_aw_valid_i && slv_aw_ready_o;

  assign mst_aw_o       = aw_q;
  assign mst_aw_valid_o = aw_valid_q;
  assign burst_start_o  = aw_valid_q && mst_aw_ready_i;

  assign burst_ctx_o    = ctx_q;
  assign w_open_o       = (state_q != upsize_pkg::W_IDLE);

  // --------------------
  // State
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= upsize_pkg::W_IDLE;
      aw_valid_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        state_q <= upsize ? upsize_pkg::W_INCR_UPSIZE : upsize_pkg::W_PASSTHROUGH;
      end else if (burst_done_i) begin
        state_q <= upsize_pkg::W_IDLE;
      end

      if (aw_hs) begin
        aw_valid_q <= 1'b1;
      end else if (burst_start_o) begin
        aw_valid_q <= 1'b0;
      end
    end
  end

  // Registered wide AW and the burst context
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q                 <= slv_aw_i;
      ctx_q.start_addr     <= slv_aw_i.addr;
      ctx_q.size           <= slv_aw_i.size;
      ctx_q.len            <= slv_aw_i.len;
      ctx_q.upsize         <= upsize;
      if (upsize) begin
        aw_q.len  <= wide_len;
        aw_q.size <= upsize_pkg::WIDE_SIZE;
      end
    end
  end

  // AW payload holds while the slave stalls it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mst_aw_valid_o && !mst_aw_ready_i |=> mst_aw_valid_o && $stable(mst_aw_o));

endmodule

// ==== hw/upsize_pkg.sv ====
`include "upsize_config.svh"

package upsize_pkg;

  // --------------------
  // Vector types
  // --------------------

  typedef logic [`UPS_ADDR_WIDTH-1:0]       addr_t;
  typedef logic [`UPS_ID_WIDTH-1:0]         id_t;
  typedef logic [`UPS_LEN_WIDTH-1:0]        len_t;
  typedef logic [`UPS_SIZE_WIDTH-1:0]       size_t;
  typedef logic [1:0]                       burst_t;
  typedef logic [3:0]                       cache_t;
  typedef logic [1:0]                       resp_t;

  typedef logic [`UPS_NARROW_WIDTH-1:0]     narrow_data_t;
  typedef logic [`UPS_NARROW_WIDTH/8-1:0]   narrow_strb_t;
  typedef logic [`UPS_WIDE_WIDTH-1:0]       wide_data_t;
  typedef logic [`UPS_WIDE_WIDTH/8-1:0]     wide_strb_t;

  // --------------------
  // Constants
  // --------------------

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  // Bit 1 of AxCACHE allows merging of beats
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  // Full size of a wide beat
  localparam size_t WIDE_SIZE = size_t'($clog2(`UPS_WIDE_WIDTH / 8));

  // Write path FSM
  typedef enum logic [1:0] {
    W_IDLE,
    W_PASSTHROUGH,
    W_INCR_UPSIZE
  } w_state_t;

  // --------------------
  // Channel payloads
  // --------------------

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    cache_t cache;
  } aw_chan_t;

  typedef struct packed {
    narrow_data_t data;
    narrow_strb_t strb;
    logic         last;
  } narrow_w_t;

  typedef struct packed {
    wide_data_t data;
    wide_strb_t strb;
    logic       last;
  } wide_w_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // What the packer needs to walk one narrow burst
  typedef struct packed {
    addr_t start_addr;
    size_t size;
    len_t  len;
    logic  upsize;
  } burst_ctx_t;

endpackage

// ==== hw/upsize_config.svh ====
`ifndef UPSIZE_CONFIG_SVH
`define UPSIZE_CONFIG_SVH

// --------------------
// Bus widths
// --------------------

// Byte address and transaction ID
`define UPS_ADDR_WIDTH   32
`define UPS_ID_WIDTH     4

// Narrow side toward the master, wide side toward the slave
`define UPS_NARROW_WIDTH 32
`define UPS_WIDE_WIDTH   64

// --------------------
// Burst fields
// --------------------

`define UPS_LEN_WIDTH    8
`define UPS_SIZE_WIDTH   3

`endif
